/* dv/tb_mem_rd_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_cfg.svh"

module tb_mem_rd_subsys;

    localparam int NC         = `NUM_CLIENTS;
    localparam int DEPTH      = 2 ** `MEM_ADDR_WID;
    localparam int WAIT_LIMIT = 400;

    logic                       clk;
    logic                       reset;
    logic                       wr_en;
    mem_rd_pkg::addr_t          wr_addr;
    mem_rd_pkg::data_t          wr_data;
    logic [NC-1:0]              job_valid;
    arb_pkg::sum_job_t [NC-1:0] job;
    logic [NC-1:0]              busy;
    logic [NC-1:0]              done;
    mem_rd_pkg::data_t [NC-1:0] sum;

    logic [31:0]       lfsr_q;
    mem_rd_pkg::data_t model_mem [DEPTH];  // Mirrors every write to the DUT memory.
    mem_rd_pkg::addr_t job_start [NC];
    arb_pkg::job_len_t job_len [NC];
    mem_rd_pkg::data_t exp_sum [NC];

    mem_rd_subsys_top uut (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .job_valid (job_valid),
        .job       (job),
        .busy      (busy),
        .done      (done),
        .sum       (sum)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // Modulo 2^32 total of the model words, addresses wrapping past the top.
    function automatic mem_rd_pkg::data_t block_sum(input int start, input int words);
        mem_rd_pkg::data_t acc;
        acc = '0;
        for (int k = 0; k < words; k++) begin
            acc = acc + model_mem[(start + k) % DEPTH];
        end
        return acc;
    endfunction

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR: %s is %h, expected %h", name, got, expected);
            stop_on_failure();
        end
    endtask

    // Writes random words to every address; engines must be idle.
    task automatic fill_memory();
        mem_rd_pkg::data_t word;
        check_value("busy", busy, '0);
        for (int a = 0; a < DEPTH; a++) begin
            word         = rand_bits(32);
            wr_en        = 1'b1;
            wr_addr      = mem_rd_pkg::addr_t'(a);
            wr_data      = word;
            model_mem[a] = word;
            @(posedge clk);
            #2;
        end
        wr_en = 1'b0;
    endtask

    task automatic start_jobs(input logic [NC-1:0] mask);
        for (int i = 0; i < NC; i++) begin
            job[i].start = job_start[i];
            job[i].len   = job_len[i];
            if (mask[i]) begin
                exp_sum[i] = block_sum(int'(job_start[i]), int'(job_len[i]) + 1);
            end
        end
        job_valid = mask;
        @(posedge clk);
        #2;
        job_valid = '0;
        for (int i = 0; i < NC; i++) begin
            if (mask[i]) begin
                check_value($sformatf("busy[%0d]", i), busy[i], 1'b1);
            end
        end
    endtask

    task automatic wait_jobs(input logic [NC-1:0] mask);
        logic [NC-1:0] pending;
        int            cycles;
        pending = mask;
        cycles  = 0;
        while (pending != '0) begin
            if (cycles == WAIT_LIMIT) begin
                $display("Timeout: engines %b did not finish their jobs within %0d cycles.",
                         pending, WAIT_LIMIT);
                stop_on_failure();
            end
            @(posedge clk);
            #2;
            cycles++;
            for (int i = 0; i < NC; i++) begin
                if (pending[i] && done[i]) begin
                    check_value($sformatf("busy[%0d]", i), busy[i], 1'b0);
                    check_value($sformatf("sum[%0d]", i), sum[i], exp_sum[i]);
                    pending[i] = 1'b0;
                end else if (pending[i]) begin
                    check_value($sformatf("busy[%0d]", i), busy[i], 1'b1);
                end else begin
                    check_value($sformatf("done[%0d]", i), done[i], 1'b0);
                end
            end
        end
        @(posedge clk);  // Done is a single pulse and the sums hold.
        #2;
        for (int i = 0; i < NC; i++) begin
            check_value($sformatf("done[%0d]", i), done[i], 1'b0);
            if (mask[i]) begin
                check_value($sformatf("sum[%0d]", i), sum[i], exp_sum[i]);
            end
        end
    endtask

    task automatic run_jobs(input logic [NC-1:0] mask);
        start_jobs(mask);
        wait_jobs(mask);
    endtask

    initial begin
        int eng;
        lfsr_q    = 32'h480f;
        reset     = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        job_valid = '0;
        job       = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < NC; i++) begin
            check_value($sformatf("busy[%0d]", i), busy[i], 1'b0);
            check_value($sformatf("done[%0d]", i), done[i], 1'b0);
            check_value($sformatf("sum[%0d]", i), sum[i], 32'h0);
        end

        // Single-word jobs return the written word itself.
        fill_memory();
        for (int i = 0; i < NC; i++) begin
            job_start[i] = mem_rd_pkg::addr_t'(rand_bits(8));
            job_len[i]   = '0;
            run_jobs(NC'(1) << i);
        end

        for (int n = 0; n < 30; n++) begin
            eng            = int'(rand_bits(2)) % NC;
            job_start[eng] = mem_rd_pkg::addr_t'(rand_bits(8));
            job_len[eng]   = arb_pkg::job_len_t'(rand_bits(4));
            run_jobs(NC'(1) << eng);
        end

        // Jobs that run past address 255.
        for (int i = 0; i < NC; i++) begin
            job_start[i] = mem_rd_pkg::addr_t'(8'hf4 + rand_bits(3));
            job_len[i]   = arb_pkg::job_len_t'(15);
            run_jobs(NC'(1) << i);
        end

        for (int round = 0; round < 4; round++) begin
            if (round > 0) begin
                fill_memory();
            end
            for (int n = 0; n < 15; n++) begin
                for (int i = 0; i < NC; i++) begin
                    job_start[i] = mem_rd_pkg::addr_t'(rand_bits(8));
                    job_len[i]   = arb_pkg::job_len_t'(rand_bits(4));
                end
                run_jobs({NC{1'b1}});
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule : tb_mem_rd_subsys

`default_nettype wire

/* logic/arb_pkg.sv */
`default_nettype none

`include "mem_rd_cfg.svh"

package arb_pkg;

    // Engine index, also used to tag reads in flight.
    typedef logic [$clog2(`NUM_CLIENTS)-1:0] client_id_t;

    typedef logic [`JOB_LEN_WID-1:0] job_len_t;

    typedef struct packed {
        mem_rd_pkg::addr_t start;
        job_len_t          len;    // Word count minus one.
    } sum_job_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        DONE
    } engine_state_t;

endpackage : arb_pkg

`default_nettype wire

/* logic/block_sum_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module block_sum_engine (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     job_valid,
    input  wire arb_pkg::sum_job_t        job,
    output logic                          busy,
    output logic                          done,
    output mem_rd_pkg::data_t             sum,
    output mem_rd_pkg::mem_rd_req_t       rd_req,
    input  wire mem_rd_pkg::mem_rd_rsp_t  rd_rsp
);

    arb_pkg::engine_state_t state;
    arb_pkg::job_len_t      len_q;
    arb_pkg::job_len_t      issue_cnt;
    arb_pkg::job_len_t      ack_cnt;
    mem_rd_pkg::addr_t      rd_addr;
    logic                   job_take;
    logic                   rd_fire;
    logic                   last_issue;
    logic                   last_ack;

    assign busy = (state == arb_pkg::ISSUE) || (state == arb_pkg::DRAIN);
    assign done = (state == arb_pkg::DONE);

    assign job_take   = job_valid && !busy;  // Also taken in the DONE cycle.
    assign rd_fire    = rd_req.req && rd_rsp.rdy;
    assign last_issue = rd_fire && (issue_cnt == len_q);
    assign last_ack   = rd_rsp.ack && (ack_cnt == len_q);

    always_comb begin
        rd_req.req  = (state == arb_pkg::ISSUE);
        rd_req.addr = rd_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_pkg::IDLE;
            sum   <= '0;
        end else begin
            case (state)
                arb_pkg::IDLE, arb_pkg::DONE: begin
                    if (job_take) begin
                        state <= arb_pkg::ISSUE;
                        sum   <= '0;
                    end else begin
                        state <= arb_pkg::IDLE;
                    end
                end
                arb_pkg::ISSUE: begin
                    if (last_issue) begin
                        state <= arb_pkg::DRAIN;
                    end
                end
                arb_pkg::DRAIN: begin
                    if (last_ack) begin
                        state <= arb_pkg::DONE;
                    end
                end
                default: state <= arb_pkg::IDLE;
            endcase
            if (rd_rsp.ack) begin
                sum <= sum + rd_rsp.data;  // Wraps modulo 2^32.
            end
        end
    end

    // Address and counters are loaded with each job.
    always_ff @(posedge clk) begin
        if (job_take) begin
            len_q     <= job.len;
            rd_addr   <= job.start;
            issue_cnt <= '0;
            ack_cnt   <= '0;
        end else begin
            if (rd_fire) begin
                rd_addr   <= rd_addr + 1'b1;  // wraps past 255
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (rd_rsp.ack) begin
                ack_cnt <= ack_cnt + 1'b1;
            end
        end
    end

    // Responses must be routed only to an engine with reads in flight.
    a_no_idle_ack: assert property (@(posedge clk) disable iff (reset)
        rd_rsp.ack |-> (state != arb_pkg::IDLE));

endmodule : block_sum_engine

`default_nettype wire

/* logic/lookup_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_cfg.svh"

module lookup_mem (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire mem_rd_pkg::mem_rd_req_t  rd_req,
    output mem_rd_pkg::mem_rd_rsp_t       rd_rsp,
    input  wire logic                     wr_en,
    input  wire mem_rd_pkg::addr_t        wr_addr,
    input  wire mem_rd_pkg::data_t        wr_data
);

    localparam int LAT   = `MEM_RD_LATENCY;
    localparam int DEPTH = 2 ** `MEM_ADDR_WID;

    mem_rd_pkg::data_t mem [DEPTH];

    logic [LAT-1:0]    pipe_vld;
    mem_rd_pkg::data_t pipe_data [LAT];
    logic              rd_fire;

    assign rd_fire = rd_req.req && rd_rsp.rdy;

    always_comb begin
        rd_rsp.rdy  = 1'b1;  // Always ready; the arbiter does the gating.
        rd_rsp.ack  = pipe_vld[LAT-1];
        rd_rsp.data = pipe_data[LAT-1];
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Valid bits for each read stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld[0] <= rd_fire;
            for (int s = 1; s < LAT; s++) begin
                pipe_vld[s] <= pipe_vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            pipe_data[0] <= mem[rd_req.addr];
        end
        for (int s = 1; s < LAT; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    // A read racing a write would return stale or mixed data.
    a_no_rd_during_wr: assert property (@(posedge clk) disable iff (reset)
        rd_req.req |-> !wr_en);

endmodule : lookup_mem

`default_nettype wire

/* logic/mem_rd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_cfg.svh"

module mem_rd_arbiter (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic                                          wr_en,
    input  wire mem_rd_pkg::mem_rd_req_t [`NUM_CLIENTS-1:0]    client_req,
    output mem_rd_pkg::mem_rd_rsp_t      [`NUM_CLIENTS-1:0]    client_rsp,
    output mem_rd_pkg::mem_rd_req_t                            mem_req,
    input  wire mem_rd_pkg::mem_rd_rsp_t                       mem_rsp
);

    localparam int LAT = `MEM_RD_LATENCY;

    arb_pkg::client_id_t       last_id;
    arb_pkg::client_id_t       win_id;
    logic                      win_vld;
    logic                      grant;
    logic [`NUM_CLIENTS-1:0]   rdy_vec;

    // One owner tag per read in flight, aligned with the memory pipeline.
    logic [LAT-1:0]            own_vld;
    arb_pkg::client_id_t       own_id [LAT];

    // Round-robin search, starting just after the last engine granted.
    always_comb begin
        int cand;
        win_vld = 1'b0;
        win_id  = '0;
        for (int i = 1; i <= `NUM_CLIENTS; i++) begin
            cand = (int'(last_id) + i) % `NUM_CLIENTS;
            if (!win_vld && client_req[cand].req) begin
                win_vld = 1'b1;
                win_id  = arb_pkg::client_id_t'(cand);
            end
        end
    end

    // Writes own the memory port for the whole cycle.
    assign grant = win_vld && !wr_en && mem_rsp.rdy;

    always_comb begin
        mem_req.req  = grant;
        mem_req.addr = client_req[win_id].addr;
    end

    always_comb begin
        for (int i = 0; i < `NUM_CLIENTS; i++) begin
            rdy_vec[i]         = grant && (win_id == arb_pkg::client_id_t'(i));
            client_rsp[i].rdy  = rdy_vec[i];
            client_rsp[i].ack  = mem_rsp.ack && own_vld[LAT-1] &&
                                 (own_id[LAT-1] == arb_pkg::client_id_t'(i));
            client_rsp[i].data = mem_rsp.data;  // Only the owner sees ack.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            own_vld <= '0;
            last_id <= arb_pkg::client_id_t'(`NUM_CLIENTS - 1);  // Engine 0 goes first.
        end else begin
            own_vld[0] <= grant;
            for (int s = 1; s < LAT; s++) begin
                own_vld[s] <= own_vld[s-1];
            end
            if (grant) begin
                last_id <= win_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        own_id[0] <= win_id;
        for (int s = 1; s < LAT; s++) begin
            own_id[s] <= own_id[s-1];
        end
    end

    a_one_rdy: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rdy_vec));

    // The owner pipeline must stay in step with the memory read pipeline.
    a_rsp_owned: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.ack |-> own_vld[LAT-1]);

endmodule : mem_rd_arbiter

`default_nettype wire

/* logic/mem_rd_cfg.svh */
`ifndef MEM_RD_CFG_SVH
`define MEM_RD_CFG_SVH

// Memory word address width; the memory holds 2**MEM_ADDR_WID words.
`define MEM_ADDR_WID 8

// Memory word width.
`define MEM_DATA_WID 32

// Number of checksum engines sharing the read port.
`define NUM_CLIENTS 3

// Cycles from an accepted read to its ack.
`define MEM_RD_LATENCY 2

// Job word count, encoded as length minus one.
`define JOB_LEN_WID 4

`endif

/* logic/mem_rd_pkg.sv */
`default_nettype none

`include "mem_rd_cfg.svh"

package mem_rd_pkg;

    typedef logic [`MEM_ADDR_WID-1:0] addr_t;
    typedef logic [`MEM_DATA_WID-1:0] data_t;

    // Controller side of the read channel.
    typedef struct packed {
        logic  req;   // Held high with addr until rdy is seen.
        addr_t addr;
    } mem_rd_req_t;

    // Peripheral side of the read channel.
    typedef struct packed {
        logic  rdy;   // Read accepted when req and rdy are both high.
        logic  ack;   // One pulse per accepted read, in order.
        data_t data;  // Valid in the ack cycle only.
    } mem_rd_rsp_t;

endpackage : mem_rd_pkg

`default_nettype wire

/* logic/mem_rd_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_rd_cfg.svh"

module mem_rd_subsys_top (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire logic                                    wr_en,
    input  wire mem_rd_pkg::addr_t                       wr_addr,
    input  wire mem_rd_pkg::data_t                       wr_data,
    input  wire logic [`NUM_CLIENTS-1:0]                 job_valid,
    input  wire arb_pkg::sum_job_t [`NUM_CLIENTS-1:0]    job,
    output logic [`NUM_CLIENTS-1:0]                      busy,
    output logic [`NUM_CLIENTS-1:0]                      done,
    output mem_rd_pkg::data_t [`NUM_CLIENTS-1:0]         sum
);

    mem_rd_pkg::mem_rd_req_t [`NUM_CLIENTS-1:0] client_req;
    mem_rd_pkg::mem_rd_rsp_t [`NUM_CLIENTS-1:0] client_rsp;
    mem_rd_pkg::mem_rd_req_t                    mem_req;
    mem_rd_pkg::mem_rd_rsp_t                    mem_rsp;

    for (genvar i = 0; i < `NUM_CLIENTS; i++) begin : g_engine
        block_sum_engine u_engine (
            .clk       (clk),
            .reset     (reset),
            .job_valid (job_valid[i]),
            .job       (job[i]),
            .busy      (busy[i]),
            .done      (done[i]),
            .sum       (sum[i]),
            .rd_req    (client_req[i]),
            .rd_rsp    (client_rsp[i])
        );
    end

    // The write port bypasses the arbiter, which holds off reads meanwhile.
    mem_rd_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .client_req (client_req),
        .client_rsp (client_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    lookup_mem u_mem (
        .clk     (clk),
        .reset   (reset),
        .rd_req  (mem_req),
        .rd_rsp  (mem_rsp),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule : mem_rd_subsys_top

`default_nettype wire

/* sim.f */
+incdir+logic
logic/mem_rd_pkg.sv
logic/arb_pkg.sv
logic/mem_rd_arbiter.sv
logic/lookup_mem.sv
logic/block_sum_engine.sv
logic/mem_rd_subsys_top.sv
dv/tb_mem_rd_subsys.sv
